// File: verilog/bp_me_axil_pkg.sv
`default_nettype none

package bp_me_axil_pkg;

  localparam int paddr_width_gp   = 32;
  localparam int payload_width_gp = 8;

  // Memory message types carried on the forward stream
  typedef enum logic [1:0]
  {
    e_mem_rd = 2'b00
    , e_mem_wr = 2'b01
  } bp_mem_msg_e;

  // Access size as log2 of the byte count
  typedef enum logic [2:0]
  {
    e_size_1 = 3'b000
    , e_size_2 = 3'b001
    , e_size_4 = 3'b010
    , e_size_8 = 3'b011
  } bp_msg_size_e;

  // Shared by forward and reverse, reverse echoes forward
  typedef struct packed
  {
    bp_mem_msg_e                 msg_type;
    bp_msg_size_e                size;
    logic [paddr_width_gp-1:0]   addr;
    logic [payload_width_gp-1:0] payload;
  } bp_mem_header_s;

  typedef enum logic [1:0]
  {
    e_axil_okay = 2'b00
    , e_axil_slverr = 2'b10
  } axil_resp_e;

endpackage

`default_nettype wire

// File: verilog/bp_me_axil_rdata_pack.sv
`timescale 1ns/10ps
`default_nettype none

module bp_me_axil_rdata_pack
  import bp_me_axil_pkg::*;
  #(parameter int data_width_p = 64
    , localparam int mask_width_lp = data_width_p >> 3
    , localparam int sel_width_lp = $clog2(mask_width_lp)
    )
  (input logic [data_width_p-1:0]    data_i
   , input logic [sel_width_lp-1:0]  sel_i
   , input bp_msg_size_e             size_i
   , output logic [data_width_p-1:0] data_o
   );

  logic [data_width_p-1:0] shifted;

  // Bring the addressed byte lane down to bit zero
  assign shifted = data_i >> {sel_i, 3'b000};

  always_comb
  begin
    case (size_i)
      e_size_1: data_o = {mask_width_lp{shifted[0+:8]}};
      e_size_2: data_o = {(mask_width_lp/2){shifted[0+:16]}};
      e_size_4: data_o = {(mask_width_lp/4){shifted[0+:32]}};
      // Full bus width or wider
      default: data_o = data_i;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/bp_axil_fifo_master.sv
`timescale 1ns/10ps
`default_nettype none

module bp_axil_fifo_master
  import bp_me_axil_pkg::*;
  #(parameter int axil_data_width_p = 64
    , parameter int axil_addr_width_p = 32
    , localparam int axil_mask_width_lp = axil_data_width_p >> 3
    )
  (input logic                             clk_i
   , input logic                           reset_i

   // Command side
   , input logic [axil_data_width_p-1:0]   data_i
   , input logic [axil_addr_width_p-1:0]   addr_i
   , input logic                           v_i
   , input logic                           w_i
   , input logic [axil_mask_width_lp-1:0]  wmask_i
   , output logic                          ready_and_o

   // Response side
   , output logic [axil_data_width_p-1:0]  data_o
   , output logic                          v_o
   , input logic                           ready_and_i

   , output logic [axil_addr_width_p-1:0]  m_axil_awaddr_o
   , output logic [2:0]                    m_axil_awprot_o
   , output logic                          m_axil_awvalid_o
   , input logic                           m_axil_awready_i

   , output logic [axil_data_width_p-1:0]  m_axil_wdata_o
   , output logic [axil_mask_width_lp-1:0] m_axil_wstrb_o
   , output logic                          m_axil_wvalid_o
   , input logic                           m_axil_wready_i

   , input axil_resp_e                     m_axil_bresp_i
   , input logic                           m_axil_bvalid_i
   , output logic                          m_axil_bready_o

   , output logic [axil_addr_width_p-1:0]  m_axil_araddr_o
   , output logic [2:0]                    m_axil_arprot_o
   , output logic                          m_axil_arvalid_o
   , input logic                           m_axil_arready_i

   , input logic [axil_data_width_p-1:0]   m_axil_rdata_i
   , input axil_resp_e                     m_axil_rresp_i
   , input logic                           m_axil_rvalid_i
   , output logic                          m_axil_rready_o
   );

  typedef enum logic [2:0]
  {
    e_ready
    , e_write_req
    , e_write_resp
    , e_read_req
    , e_read_resp
  } state_e;

  state_e state_r;
  logic awvalid_r, wvalid_r, arvalid_r, resp_v_r;
  logic aw_done, w_done;
  logic [axil_addr_width_p-1:0] addr_r;
  logic [axil_data_width_p-1:0] wdata_r, rdata_r;
  logic [axil_mask_width_lp-1:0] wstrb_r;

  assign ready_and_o = (state_r == e_ready);

  // Each write channel completes on its own handshake
  assign aw_done = ~awvalid_r | m_axil_awready_i;
  assign w_done  = ~wvalid_r | m_axil_wready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= e_ready;
      awvalid_r <= 1'b0;
      wvalid_r  <= 1'b0;
      arvalid_r <= 1'b0;
      resp_v_r  <= 1'b0;
    end
    else
    begin
      case (state_r)
        e_ready:
          if (v_i)
          begin
            awvalid_r <= w_i;
            wvalid_r  <= w_i;
            arvalid_r <= ~w_i;
            state_r   <= w_i ? e_write_req : e_read_req;
          end
        e_write_req:
        begin
          if (m_axil_awready_i)
            awvalid_r <= 1'b0;
          if (m_axil_wready_i)
            wvalid_r <= 1'b0;
          if (aw_done & w_done)
            state_r <= e_write_resp;
        end
        e_read_req:
          if (m_axil_arready_i)
          begin
            arvalid_r <= 1'b0;
            state_r   <= e_read_resp;
          end
        e_write_resp, e_read_resp:
          if (resp_v_r)
          begin
            if (ready_and_i)
            begin
              resp_v_r <= 1'b0;
              state_r  <= e_ready;
            end
          end
          else if (m_axil_bready_o & m_axil_bvalid_i)
            resp_v_r <= 1'b1;
          else if (m_axil_rready_o & m_axil_rvalid_i)
            resp_v_r <= 1'b1;
        default: state_r <= e_ready;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ready_and_o & v_i)
    begin
      addr_r  <= addr_i;
      wdata_r <= data_i;
      wstrb_r <= wmask_i;
    end
    if (m_axil_rready_o & m_axil_rvalid_i)
      rdata_r <= m_axil_rdata_i;
  end

  assign m_axil_awaddr_o  = addr_r;
  assign m_axil_awprot_o  = 3'b000;
  assign m_axil_awvalid_o = awvalid_r;
  assign m_axil_wdata_o   = wdata_r;
  assign m_axil_wstrb_o   = wstrb_r;
  assign m_axil_wvalid_o  = wvalid_r;
  assign m_axil_araddr_o  = addr_r;
  assign m_axil_arprot_o  = 3'b000;
  assign m_axil_arvalid_o = arvalid_r;

  // Stop accepting once a response is held; bresp and rresp are not checked
  assign m_axil_bready_o = (state_r == e_write_resp) & ~resp_v_r;
  assign m_axil_rready_o = (state_r == e_read_resp) & ~resp_v_r;

  assign data_o = rdata_r;
  assign v_o    = resp_v_r;

endmodule

`default_nettype wire

// File: verilog/bp_me_axil_master.sv
`timescale 1ns/10ps
`default_nettype none

module bp_me_axil_master
  import bp_me_axil_pkg::*;
  #(parameter int axil_data_width_p = 64
    , parameter int axil_addr_width_p = 32
    , localparam int axil_mask_width_lp = axil_data_width_p >> 3
    , localparam int byte_offset_width_lp = $clog2(axil_mask_width_lp)
    )
  (input logic                             clk_i
   , input logic                           reset_i

   , input bp_mem_header_s                 mem_fwd_header_i
   , input logic [axil_data_width_p-1:0]   mem_fwd_data_i
   , input logic                           mem_fwd_v_i
   , output logic                          mem_fwd_ready_and_o

   , output bp_mem_header_s                mem_rev_header_o
   , output logic [axil_data_width_p-1:0]  mem_rev_data_o
   , output logic                          mem_rev_v_o
   , input logic                           mem_rev_ready_and_i

   , output logic [axil_addr_width_p-1:0]  m_axil_awaddr_o
   , output logic [2:0]                    m_axil_awprot_o
   , output logic                          m_axil_awvalid_o
   , input logic                           m_axil_awready_i

   , output logic [axil_data_width_p-1:0]  m_axil_wdata_o
   , output logic [axil_mask_width_lp-1:0] m_axil_wstrb_o
   , output logic                          m_axil_wvalid_o
   , input logic                           m_axil_wready_i

   , input logic [1:0]                     m_axil_bresp_i
   , input logic                           m_axil_bvalid_i
   , output logic                          m_axil_bready_o

   , output logic [axil_addr_width_p-1:0]  m_axil_araddr_o
   , output logic [2:0]                    m_axil_arprot_o
   , output logic                          m_axil_arvalid_o
   , input logic                           m_axil_arready_i

   , input logic [axil_data_width_p-1:0]   m_axil_rdata_i
   , input logic [1:0]                     m_axil_rresp_i
   , input logic                           m_axil_rvalid_i
   , output logic                          m_axil_rready_o
   );

  bp_mem_header_s header_r;
  logic [axil_addr_width_p-1:0] addr_li;
  logic [axil_mask_width_lp-1:0] wmask_li;
  logic [byte_offset_width_lp-1:0] mask_shift, resp_sel;
  logic [axil_data_width_p-1:0] rdata_lo;
  logic w_li, ready_and_lo, v_lo;

  assign addr_li    = axil_addr_width_p'(mem_fwd_header_i.addr);
  assign w_li       = (mem_fwd_header_i.msg_type == e_mem_wr);
  assign mask_shift = mem_fwd_header_i.addr[0+:byte_offset_width_lp];

  // Byte strobe from size, placed at the low address bits
  always_comb
  begin
    case (mem_fwd_header_i.size)
      e_size_1: wmask_li = axil_mask_width_lp'('h1) << mask_shift;
      e_size_2: wmask_li = axil_mask_width_lp'('h3) << mask_shift;
      e_size_4: wmask_li = axil_mask_width_lp'('hF) << mask_shift;
      default: wmask_li = {axil_mask_width_lp{1'b1}};
    endcase
  end

  // One-entry header store, only one request in flight
  always_ff @(posedge clk_i)
  begin
    if (mem_fwd_v_i & ready_and_lo)
      header_r <= mem_fwd_header_i;
  end

  assign mem_fwd_ready_and_o = ready_and_lo;
  assign mem_rev_header_o    = header_r;
  assign mem_rev_v_o         = v_lo;

  // Offset aligned down to the access size
  assign resp_sel = header_r.addr[0+:byte_offset_width_lp]
                    & ({byte_offset_width_lp{1'b1}} << header_r.size);

  bp_me_axil_rdata_pack
    #(.data_width_p(axil_data_width_p))
    rdata_pack
    (.data_i(rdata_lo)
     , .sel_i(resp_sel)
     , .size_i(header_r.size)
     , .data_o(mem_rev_data_o)
     );

  bp_axil_fifo_master
    #(.axil_data_width_p(axil_data_width_p)
      , .axil_addr_width_p(axil_addr_width_p)
      )
    fifo_master
    (.data_i(mem_fwd_data_i)
     , .addr_i(addr_li)
     , .v_i(mem_fwd_v_i)
     , .w_i(w_li)
     , .wmask_i(wmask_li)
     , .ready_and_o(ready_and_lo)
     , .data_o(rdata_lo)
     , .v_o(v_lo)
     , .ready_and_i(mem_rev_ready_and_i)
     , .m_axil_bresp_i(axil_resp_e'(m_axil_bresp_i))
     , .m_axil_rresp_i(axil_resp_e'(m_axil_rresp_i))
     , .*
     );

endmodule

`default_nettype wire

// File: verilog/bp_axil_mem_target.sv
`timescale 1ns/10ps
`default_nettype none

module bp_axil_mem_target
  import bp_me_axil_pkg::*;
  #(parameter int axil_data_width_p = 64
    , parameter int axil_addr_width_p = 32
    , parameter int mem_els_p = 256
    , localparam int axil_mask_width_lp = axil_data_width_p >> 3
    )
  (input logic                             clk_i
   , input logic                           reset_i

   , input logic [axil_addr_width_p-1:0]   s_axil_awaddr_i
   , input logic [2:0]                     s_axil_awprot_i
   , input logic                           s_axil_awvalid_i
   , output logic                          s_axil_awready_o

   , input logic [axil_data_width_p-1:0]   s_axil_wdata_i
   , input logic [axil_mask_width_lp-1:0]  s_axil_wstrb_i
   , input logic                           s_axil_wvalid_i
   , output logic                          s_axil_wready_o

   , output axil_resp_e                    s_axil_bresp_o
   , output logic                          s_axil_bvalid_o
   , input logic                           s_axil_bready_i

   , input logic [axil_addr_width_p-1:0]   s_axil_araddr_i
   , input logic [2:0]                     s_axil_arprot_i
   , input logic                           s_axil_arvalid_i
   , output logic                          s_axil_arready_o

   , output logic [axil_data_width_p-1:0]  s_axil_rdata_o
   , output axil_resp_e                    s_axil_rresp_o
   , output logic                          s_axil_rvalid_o
   , input logic                           s_axil_rready_i
   );

  localparam int off_width_lp = $clog2(axil_mask_width_lp);
  localparam int idx_width_lp = $clog2(mem_els_p);

  logic [axil_data_width_p-1:0] mem_r [mem_els_p];
  logic [axil_data_width_p-1:0] rdata_r;
  logic [idx_width_lp-1:0] widx, ridx;
  logic bvalid_r, rvalid_r, wr_fire, rd_fire;

  // Word index above the byte offset, upper bits wrap
  assign widx = s_axil_awaddr_i[off_width_lp+:idx_width_lp];
  assign ridx = s_axil_araddr_i[off_width_lp+:idx_width_lp];

  // Address and data are taken together
  assign s_axil_awready_o = s_axil_awvalid_i & s_axil_wvalid_i & ~bvalid_r;
  assign s_axil_wready_o  = s_axil_awready_o;
  assign wr_fire          = s_axil_awready_o;

  assign s_axil_arready_o = ~rvalid_r;
  assign rd_fire          = s_axil_arvalid_i & s_axil_arready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < mem_els_p; i++)
        mem_r[i] <= '0;
    end
    else if (wr_fire)
    begin
      for (int b = 0; b < axil_mask_width_lp; b++)
        if (s_axil_wstrb_i[b])
          mem_r[widx][8*b+:8] <= s_axil_wdata_i[8*b+:8];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      bvalid_r <= 1'b0;
      rvalid_r <= 1'b0;
    end
    else
    begin
      if (wr_fire)
        bvalid_r <= 1'b1;
      else if (s_axil_bready_i)
        bvalid_r <= 1'b0;
      if (rd_fire)
        rvalid_r <= 1'b1;
      else if (s_axil_rready_i)
        rvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_fire)
      rdata_r <= mem_r[ridx];
  end

  assign s_axil_bvalid_o = bvalid_r;
  assign s_axil_bresp_o  = e_axil_okay;
  assign s_axil_rvalid_o = rvalid_r;
  assign s_axil_rdata_o  = rdata_r;
  assign s_axil_rresp_o  = e_axil_okay;

endmodule

`default_nettype wire

// File: verilog/bp_me_axil_top.sv
`timescale 1ns/10ps
`default_nettype none

module bp_me_axil_top
  import bp_me_axil_pkg::*;
  #(parameter int axil_data_width_p = 64
    , parameter int axil_addr_width_p = 32
    , parameter int mem_els_p = 256
    , localparam int axil_mask_width_lp = axil_data_width_p >> 3
    )
  (input logic                            clk_i
   , input logic                          reset_i

   , input bp_mem_header_s                mem_fwd_header_i
   , input logic [axil_data_width_p-1:0]  mem_fwd_data_i
   , input logic                          mem_fwd_v_i
   , output logic                         mem_fwd_ready_and_o

   , output bp_mem_header_s               mem_rev_header_o
   , output logic [axil_data_width_p-1:0] mem_rev_data_o
   , output logic                         mem_rev_v_o
   , input logic                          mem_rev_ready_and_i
   );

  logic [axil_addr_width_p-1:0] m_axil_awaddr_o, m_axil_araddr_o;
  logic [2:0] m_axil_awprot_o, m_axil_arprot_o;
  logic m_axil_awvalid_o, m_axil_awready_i;
  logic [axil_data_width_p-1:0] m_axil_wdata_o, m_axil_rdata_i;
  logic [axil_mask_width_lp-1:0] m_axil_wstrb_o;
  logic m_axil_wvalid_o, m_axil_wready_i;
  logic [1:0] m_axil_bresp_i, m_axil_rresp_i;
  logic m_axil_bvalid_i, m_axil_bready_o;
  logic m_axil_arvalid_o, m_axil_arready_i;
  logic m_axil_rvalid_i, m_axil_rready_o;

  bp_me_axil_master
    #(.axil_data_width_p(axil_data_width_p)
      , .axil_addr_width_p(axil_addr_width_p)
      )
    bridge
    (.*);

  bp_axil_mem_target
    #(.axil_data_width_p(axil_data_width_p)
      , .axil_addr_width_p(axil_addr_width_p)
      , .mem_els_p(mem_els_p)
      )
    mem_target
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .s_axil_awaddr_i(m_axil_awaddr_o)
     , .s_axil_awprot_i(m_axil_awprot_o)
     , .s_axil_awvalid_i(m_axil_awvalid_o)
     , .s_axil_awready_o(m_axil_awready_i)
     , .s_axil_wdata_i(m_axil_wdata_o)
     , .s_axil_wstrb_i(m_axil_wstrb_o)
     , .s_axil_wvalid_i(m_axil_wvalid_o)
     , .s_axil_wready_o(m_axil_wready_i)
     , .s_axil_bresp_o(m_axil_bresp_i)
     , .s_axil_bvalid_o(m_axil_bvalid_i)
     , .s_axil_bready_i(m_axil_bready_o)
     , .s_axil_araddr_i(m_axil_araddr_o)
     , .s_axil_arprot_i(m_axil_arprot_o)
     , .s_axil_arvalid_i(m_axil_arvalid_o)
     , .s_axil_arready_o(m_axil_arready_i)
     , .s_axil_rdata_o(m_axil_rdata_i)
     , .s_axil_rresp_o(m_axil_rresp_i)
     , .s_axil_rvalid_o(m_axil_rvalid_i)
     , .s_axil_rready_i(m_axil_rready_o)
     );

endmodule

`default_nettype wire

// File: verification/bp_me_axil_assert.sv
`timescale 1ns/10ps
`default_nettype none

module bp_me_axil_assert
  (input logic   clk_i
   , input logic reset_i
   , input logic fwd_v_i
   , input logic fwd_ready_i
   , input logic rev_v_i
   , input logic rev_ready_i
   , input logic awvalid_i
   , input logic awready_i
   , input logic wvalid_i
   , input logic wready_i
   , input logic arvalid_i
   , input logic arready_i
   );

  logic pending_r;
  int fail_count = 0;

  // Set by an accepted command and cleared when its response is taken
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pending_r <= 1'b0;
    else if (fwd_v_i & fwd_ready_i)
      pending_r <= 1'b1;
    else if (rev_v_i & rev_ready_i)
      pending_r <= 1'b0;
  end

  aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    awvalid_i && !awready_i |=> awvalid_i)
  else
  begin
    fail_count++;
    $error("awvalid dropped before awready");
  end

  w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    wvalid_i && !wready_i |=> wvalid_i)
  else
  begin
    fail_count++;
    $error("wvalid dropped before wready");
  end

  ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    arvalid_i && !arready_i |=> arvalid_i)
  else
  begin
    fail_count++;
    $error("arvalid dropped before arready");
  end

  rev_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rev_v_i && !rev_ready_i |=> rev_v_i)
  else
  begin
    fail_count++;
    $error("response valid dropped before ready");
  end

  one_request: assert property (@(posedge clk_i) disable iff (reset_i)
    !(arvalid_i && awvalid_i))
  else
  begin
    fail_count++;
    $error("arvalid and awvalid active together");
  end

  rev_after_fwd: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(rev_v_i) |-> pending_r)
  else
  begin
    fail_count++;
    $error("response without an accepted command");
  end

endmodule

bind bp_axil_fifo_master bp_me_axil_assert handshake_checks
  (.clk_i(clk_i)
   , .reset_i(reset_i)
   , .fwd_v_i(v_i)
   , .fwd_ready_i(ready_and_o)
   , .rev_v_i(v_o)
   , .rev_ready_i(ready_and_i)
   , .awvalid_i(m_axil_awvalid_o)
   , .awready_i(m_axil_awready_i)
   , .wvalid_i(m_axil_wvalid_o)
   , .wready_i(m_axil_wready_i)
   , .arvalid_i(m_axil_arvalid_o)
   , .arready_i(m_axil_arready_i)
   );

`default_nettype wire

// File: verification/tb_bp_me_axil.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bp_me_axil
  import bp_me_axil_pkg::*;
  ;

  localparam int data_width_lp = 64;
  // Table, offset sweep, stall and random requests
  localparam int num_requests_lp = 16 + 31 + 3 + 40;
  localparam int timeout_limit_lp = num_requests_lp * 20 + 100;

  typedef struct packed
  {
    bp_mem_msg_e              msg_type;
    bp_msg_size_e             size;
    logic [31:0]              addr;
    logic [data_width_lp-1:0] wdata;
    logic [data_width_lp-1:0] rdata;
  } stim_row_s;

  logic clk = 1'b0;
  logic reset;
  bp_mem_header_s fwd_header, rev_header;
  logic [data_width_lp-1:0] fwd_data, rev_data;
  logic fwd_v, fwd_ready, rev_v, rev_ready;

  stim_row_s stim_q [$];
  logic [7:0] model_mem [2048];
  int error_count, check_count, cycle_count;
  integer seed = 32'he7afcf1f;

  bp_me_axil_top
    #(.axil_data_width_p(data_width_lp)
      , .axil_addr_width_p(32)
      , .mem_els_p(256)
      )
    uut
    (.clk_i(clk)
     , .reset_i(reset)
     , .mem_fwd_header_i(fwd_header)
     , .mem_fwd_data_i(fwd_data)
     , .mem_fwd_v_i(fwd_v)
     , .mem_fwd_ready_and_o(fwd_ready)
     , .mem_rev_header_o(rev_header)
     , .mem_rev_data_o(rev_data)
     , .mem_rev_v_o(rev_v)
     , .mem_rev_ready_and_i(rev_ready)
     );

  always
  begin
    #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit_lp)
    begin
      $display("Timeout: no completion within %0d cycles", timeout_limit_lp);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic int size_bytes(input bp_msg_size_e size);
    return 1 << size;
  endfunction

  task automatic check_header(input string name, input bp_mem_header_s got,
                              input bp_mem_header_s exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [data_width_lp-1:0] got,
                            input logic [data_width_lp-1:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input bp_mem_msg_e msg_type, input bp_msg_size_e size,
                         input logic [31:0] addr, input logic [data_width_lp-1:0] wdata,
                         input logic [data_width_lp-1:0] rdata);
    stim_q.push_back('{msg_type, size, addr, wdata, rdata});
  endtask

  // Only the lanes covered by size and offset change
  task automatic model_write(input logic [31:0] addr, input bp_msg_size_e size,
                             input logic [data_width_lp-1:0] data);
    logic [2:0] lane;
    for (int i = 0; i < size_bytes(size); i++)
    begin
      lane = addr[2:0] + 3'(i);
      model_mem[{addr[10:3], lane}] = 8'(data >> {lane, 3'b000});
    end
  endtask

  // Subword at the aligned offset repeated over all byte lanes
  function automatic logic [data_width_lp-1:0] expected_read(input logic [31:0] addr,
                                                             input bp_msg_size_e size);
    logic [data_width_lp-1:0] result;
    logic [2:0] base, lane;
    int n;
    n = size_bytes(size);
    base = addr[2:0] & ~3'(n - 1);
    result = '0;
    for (int i = 0; i < 8; i++)
    begin
      lane = base + 3'(i % n);
      result = {model_mem[{addr[10:3], lane}], result[data_width_lp-1:8]};
    end
    return result;
  endfunction

  task automatic run_request(input bp_mem_header_s hdr, input logic [data_width_lp-1:0] data,
                             input int stall, output bp_mem_header_s got_hdr,
                             output logic [data_width_lp-1:0] got_data);
    @(posedge clk);
    fwd_header <= hdr;
    fwd_data <= data;
    fwd_v <= 1'b1;
    rev_ready <= (stall == 0);
    do @(negedge clk); while (!fwd_ready);
    @(posedge clk);
    fwd_v <= 1'b0;
    do @(negedge clk); while (!rev_v);
    got_hdr = rev_header;
    got_data = rev_data;
    // Response must hold still while the consumer stalls
    for (int i = 0; i < stall; i++)
    begin
      @(negedge clk);
      if (!rev_v || rev_header !== got_hdr || rev_data !== got_data)
      begin
        error_count++;
        $display("Reverse message changed while mem_rev_ready_and_i was low at %0t", $time);
      end
      if (fwd_ready)
      begin
        error_count++;
        $display("Forward channel ready while a response was pending at %0t", $time);
      end
    end
    if (stall > 0)
    begin
      @(posedge clk);
      rev_ready <= 1'b1;
    end
  endtask

  task automatic issue_and_check(input bp_mem_msg_e msg_type, input bp_msg_size_e size,
                                 input logic [31:0] addr,
                                 input logic [data_width_lp-1:0] wdata,
                                 input logic [7:0] payload, input int stall,
                                 output logic [data_width_lp-1:0] got_data);
    bp_mem_header_s hdr, got_hdr;
    hdr.msg_type = msg_type;
    hdr.size = size;
    hdr.addr = addr;
    hdr.payload = payload;
    run_request(hdr, wdata, stall, got_hdr, got_data);
    check_header("mem_rev_header_o", got_hdr, hdr);
    if (msg_type == e_mem_wr)
      model_write(addr, size, wdata);
    else
      check_data("mem_rev_data_o", got_data, expected_read(addr, size));
  endtask

  initial
  begin
    logic [data_width_lp-1:0] wdata, got;
    logic [31:0] r, addr;
    logic [7:0] pattern;
    bp_msg_size_e size;
    int assert_fails;

    reset <= 1'b1;
    fwd_header <= '0;
    fwd_data <= '0;
    fwd_v <= 1'b0;
    rev_ready <= 1'b1;
    for (int i = 0; i < 2048; i++)
      model_mem[i] = 8'h00;

    add_row(e_mem_wr, e_size_8, 32'h100, 64'h0123456789abcdef, '0);
    add_row(e_mem_rd, e_size_8, 32'h100, '0, 64'h0123456789abcdef);
    add_row(e_mem_rd, e_size_4, 32'h104, '0, 64'h0123456701234567);
    add_row(e_mem_rd, e_size_4, 32'h100, '0, 64'h89abcdef89abcdef);
    add_row(e_mem_rd, e_size_2, 32'h102, '0, 64'h89ab89ab89ab89ab);
    add_row(e_mem_rd, e_size_2, 32'h106, '0, 64'h0123012301230123);
    add_row(e_mem_rd, e_size_1, 32'h105, '0, 64'h4545454545454545);
    add_row(e_mem_rd, e_size_1, 32'h100, '0, 64'hefefefefefefefef);
    add_row(e_mem_wr, e_size_1, 32'h103, 64'h5a5a5a5a5a5a5a5a, '0);
    add_row(e_mem_wr, e_size_2, 32'h104, 64'hbeefbeefbeefbeef, '0);
    add_row(e_mem_rd, e_size_8, 32'h100, '0, 64'h0123beef5aabcdef);
    add_row(e_mem_rd, e_size_1, 32'h103, '0, 64'h5a5a5a5a5a5a5a5a);
    // Upper address bits wrap onto the same word
    add_row(e_mem_rd, e_size_8, 32'h900, '0, 64'h0123beef5aabcdef);
    add_row(e_mem_wr, e_size_4, 32'h10c, 64'hcafef00dcafef00d, '0);
    add_row(e_mem_rd, e_size_8, 32'h108, '0, 64'hcafef00d00000000);
    add_row(e_mem_rd, e_size_4, 32'h10c, '0, 64'hcafef00dcafef00d);

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    foreach (stim_q[i])
    begin
      issue_and_check(stim_q[i].msg_type, stim_q[i].size, stim_q[i].addr,
                      stim_q[i].wdata, 8'(i), 0, got);
      if (stim_q[i].msg_type == e_mem_rd)
        check_data("mem_rev_data_o", got, stim_q[i].rdata);
    end

    // Every legal offset for sizes 1, 2 and 4 with a full word read back each time
    for (int s = 0; s < 3; s++)
    begin
      size = bp_msg_size_e'(3'(s));
      issue_and_check(e_mem_wr, e_size_8, 32'h200, 64'hf0e1d2c3b4a59687, 8'h20, 0, got);
      for (int off = 0; off < 8; off += size_bytes(size))
      begin
        pattern = 8'h40 + 8'(16 * s + off);
        addr = 32'h200 + 32'(off);
        issue_and_check(e_mem_wr, size, addr, {8{pattern}}, pattern, 0, got);
        issue_and_check(e_mem_rd, e_size_8, 32'h200, '0, ~pattern, 0, got);
      end
    end

    // Consumer back-pressure
    issue_and_check(e_mem_wr, e_size_8, 32'h300, 64'h1122334455667788, 8'ha5, 6, got);
    issue_and_check(e_mem_rd, e_size_4, 32'h304, '0, 8'h5a, 6, got);
    issue_and_check(e_mem_rd, e_size_8, 32'h300, '0, 8'h3c, 0, got);

    // Eight words at 0x100 with random upper bits
    for (int i = 0; i < 40; i++)
    begin
      r = $random(seed);
      size = bp_msg_size_e'({1'b0, r[1:0]});
      addr = $random(seed);
      addr = {addr[31:11], 5'b00100, addr[5:0]};
      addr[2:0] = addr[2:0] & ~3'(size_bytes(size) - 1);
      wdata = {$random(seed), $random(seed)};
      issue_and_check(r[2] ? e_mem_wr : e_mem_rd, size, addr, wdata, r[15:8], 0, got);
    end

    @(posedge clk);
    assert_fails = uut.bridge.fifo_master.handshake_checks.fail_count;
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d", check_count,
             error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
verilog/bp_me_axil_pkg.sv
verilog/bp_me_axil_rdata_pack.sv
verilog/bp_axil_fifo_master.sv
verilog/bp_me_axil_master.sv
verilog/bp_axil_mem_target.sv
verilog/bp_me_axil_top.sv
verification/bp_me_axil_assert.sv
verification/tb_bp_me_axil.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_bp_me_axil
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
